/* src/fft_pkg.sv */
`default_nettype none

package fft_pkg;

	// sample component width
	localparam int data_w = 16;
	// q8 fixed point
	localparam int frac_w = 8;

	// transform length, fixed
	localparam int n_points = 16;
	// log2 of n_points
	localparam int addr_w = 4;
	// enough for four stages
	localparam int stage_w = 2;

	// one complex word, re in the upper half
	typedef struct packed {
		logic signed [data_w-1:0] re;
		logic signed [data_w-1:0] im;
	} cplx_t;

	// both read ports of the sample ram
	typedef struct packed {
		logic [addr_w-1:0] a_addr;
		logic [addr_w-1:0] b_addr;
	} ram_rd_t;

	// both write ports, one shared enable
	typedef struct packed {
		logic en;
		logic [addr_w-1:0] a_addr;
		logic [addr_w-1:0] b_addr;
		cplx_t a_data;
		cplx_t b_data;
	} ram_wr_t;

endpackage

`default_nettype wire

/* src/fft_twiddle_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_twiddle_rom #(
	parameter int data_w = fft_pkg::data_w,
	parameter int frac_w = fft_pkg::frac_w
) (
	input wire logic i_clk,
	input wire logic [fft_pkg::addr_w-2:0] idx,
	output fft_pkg::cplx_t tw
);

	import fft_pkg::*;

	// table entries in q8
	int q8_re;
	int q8_im;

	// W16^k = cos(2pi k/16) - j sin(2pi k/16), rounded
	always_comb begin
		case (idx)
			3'd0: begin q8_re = 256;  q8_im = 0;    end
			3'd1: begin q8_re = 237;  q8_im = -98;  end
			3'd2: begin q8_re = 181;  q8_im = -181; end
			3'd3: begin q8_re = 98;   q8_im = -237; end
			3'd4: begin q8_re = 0;    q8_im = -256; end
			3'd5: begin q8_re = -98;  q8_im = -237; end
			3'd6: begin q8_re = -181; q8_im = -181; end
			default: begin q8_re = -237; q8_im = -98; end
		endcase
	end

	// rescale to frac_w, exact for frac_w of 8 and up
	// registered so tw lines up with the ram read of the same butterfly
	always_ff @(posedge i_clk) begin
		tw.re <= data_w'(q8_re * (1 << frac_w) / 256);
		tw.im <= data_w'(q8_im * (1 << frac_w) / 256);
	end

endmodule

`default_nettype wire

/* src/fft_butterfly.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_butterfly #(
	parameter int data_w = fft_pkg::data_w,
	parameter int frac_w = fft_pkg::frac_w
) (
	input wire logic i_clk,
	input wire logic rst,
	input wire fft_pkg::cplx_t a,
	input wire fft_pkg::cplx_t b,
	input wire fft_pkg::cplx_t tw,
	output fft_pkg::cplx_t y0,
	output fft_pkg::cplx_t y1
);

	// double width for the partial products
	localparam int prod_w = 2 * data_w;

	// partial products of b * tw
	logic signed [prod_w-1:0] rr;
	logic signed [prod_w-1:0] ii;
	logic signed [prod_w-1:0] ri;
	logic signed [prod_w-1:0] ir;

	// rotated b, still wide
	logic signed [prod_w-1:0] p_re;
	logic signed [prod_w-1:0] p_im;

	// sum and difference before halving
	logic signed [prod_w-1:0] s0_re;
	logic signed [prod_w-1:0] s0_im;
	logic signed [prod_w-1:0] s1_re;
	logic signed [prod_w-1:0] s1_im;

	always_comb begin
		rr = b.re * tw.re;
		ii = b.im * tw.im;
		ri = b.re * tw.im;
		ir = b.im * tw.re;
		// each product truncated back to frac_w fraction bits
		p_re = (rr >>> frac_w) - (ii >>> frac_w);
		p_im = (ri >>> frac_w) + (ir >>> frac_w);
		// a sign extended to prod_w
		s0_re = a.re + p_re;
		s0_im = a.im + p_im;
		s1_re = a.re - p_re;
		s1_im = a.im - p_im;
	end

	// halve every stage so 16 points never overflow
	always_ff @(posedge i_clk) begin
		if (rst) begin
			y0 <= '0;
			y1 <= '0;
		end else begin
			y0.re <= data_w'(s0_re >>> 1);
			y0.im <= data_w'(s0_im >>> 1);
			y1.re <= data_w'(s1_re >>> 1);
			y1.im <= data_w'(s1_im >>> 1);
		end
	end

endmodule

`default_nettype wire

/* src/fft_sample_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_sample_ram (
	input wire logic i_clk,
	input wire fft_pkg::ram_rd_t rd,
	input wire fft_pkg::ram_wr_t wr,
	output fft_pkg::cplx_t a_q,
	output fft_pkg::cplx_t b_q
);

	import fft_pkg::*;

	// sixteen complex words, flops
	cplx_t mem [n_points];

	// both reads combinational
	assign a_q = mem[rd.a_addr];
	assign b_q = mem[rd.b_addr];

	// butterfly pair written in one edge
	// host load drives both ports to the same slot
	always_ff @(posedge i_clk) begin
		if (wr.en) begin
			mem[wr.a_addr] <= wr.a_data;
			mem[wr.b_addr] <= wr.b_data;
		end
	end

endmodule

`default_nettype wire

/* src/fft_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_mem_arbiter (
	input wire logic i_clk,
	input wire logic rst,
	input wire logic busy,
	input wire fft_pkg::ram_rd_t eng_rd,
	input wire fft_pkg::ram_wr_t eng_wr,
	input wire logic ld_en,
	input wire logic [fft_pkg::addr_w-1:0] ld_addr,
	input wire fft_pkg::cplx_t ld_data,
	input wire logic [fft_pkg::addr_w-1:0] rd_addr,
	output fft_pkg::ram_rd_t ram_rd,
	output fft_pkg::ram_wr_t ram_wr,
	input wire fft_pkg::cplx_t a_q,
	output fft_pkg::cplx_t rd_data
);

	import fft_pkg::*;

	// load address with bit order flipped
	logic [addr_w-1:0] ld_rev;

	// dit input order, so bins come out natural
	always_comb begin
		for (int i = 0; i < addr_w; i++) begin
			ld_rev[i] = ld_addr[addr_w-1-i];
		end
	end

	// engine wins outright while busy
	// host loads in that window are lost
	always_comb begin
		if (busy) begin
			ram_rd = eng_rd;
			ram_wr = eng_wr;
		end else begin
			ram_rd.a_addr = rd_addr;
			ram_rd.b_addr = rd_addr;
			ram_wr.en = ld_en;
			ram_wr.a_addr = ld_rev;
			ram_wr.b_addr = ld_rev;
			ram_wr.a_data = ld_data;
			ram_wr.b_data = ld_data;
		end
	end

	// host read data, one cycle after rd_addr
	always_ff @(posedge i_clk) begin
		if (rst) begin
			rd_data <= '0;
		end else begin
			rd_data <= a_q;
		end
	end

endmodule

`default_nettype wire

/* src/fft_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_sequencer (
	input wire logic i_clk,
	input wire logic rst,
	input wire logic start,
	output logic busy,
	output logic [fft_pkg::stage_w-1:0] stage,
	output fft_pkg::ram_rd_t eng_rd,
	output logic [fft_pkg::addr_w-2:0] tw_idx,
	input wire fft_pkg::cplx_t y0,
	input wire fft_pkg::cplx_t y1,
	output fft_pkg::ram_wr_t eng_wr,
	output logic o_butterfly_done,
	output logic o_fft_cycle_done
);

	import fft_pkg::*;

	// 8 issue cycles then 2 drain cycles per stage
	localparam int bf_per_stage = n_points / 2;
	localparam int stage_len = bf_per_stage + 2;

	// cycle within the current stage
	logic [3:0] cnt;
	// butterfly index j
	logic [addr_w-2:0] j;
	logic [addr_w-1:0] span;
	logic [addr_w-1:0] offset;
	logic [addr_w-1:0] a_addr;
	logic [addr_w-1:0] b_addr;
	logic issue;

	// valid bits of the two in-flight butterflies
	logic iss_q;
	logic wr_en;
	// write-back addresses, second delay
	logic [addr_w-1:0] wa_q;
	logic [addr_w-1:0] wb_q;

	always_comb begin
		j = cnt[addr_w-2:0];
		span = addr_w'(1) << stage;
		// position of j inside its group
		offset = {1'b0, j} & (span - 1'b1);
		// group base is j with a zero bit slipped in at bit stage
		a_addr = (({1'b0, j} >> stage) << (stage + 1)) | offset;
		b_addr = a_addr + span;
		// offset * 8 / span
		tw_idx = offset[addr_w-2:0] << (addr_w - 1 - stage);
		issue = busy && (cnt < bf_per_stage);
	end

	// control state
	always_ff @(posedge i_clk) begin
		if (rst) begin
			busy <= 1'b0;
			stage <= '0;
			cnt <= '0;
			iss_q <= 1'b0;
			wr_en <= 1'b0;
			o_fft_cycle_done <= 1'b0;
		end else begin
			o_fft_cycle_done <= 1'b0;
			iss_q <= issue;
			wr_en <= iss_q;
			if (!busy) begin
				// start only counts while idle
				if (start) begin
					busy <= 1'b1;
					stage <= '0;
					cnt <= '0;
				end
			end else if (cnt == stage_len - 1) begin
				cnt <= '0;
				// wraps back to 0 after the last stage
				stage <= stage + 1'b1;
				if (stage == stage_w'(addr_w - 1)) begin
					busy <= 1'b0;
					o_fft_cycle_done <= 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// read addresses registered, then held one more cycle for write-back
	always_ff @(posedge i_clk) begin
		eng_rd.a_addr <= a_addr;
		eng_rd.b_addr <= b_addr;
		wa_q <= eng_rd.a_addr;
		wb_q <= eng_rd.b_addr;
	end

	// y0/y1 are already registered in the butterfly
	always_comb begin
		eng_wr.en = wr_en;
		eng_wr.a_addr = wa_q;
		eng_wr.b_addr = wb_q;
		eng_wr.a_data = y0;
		eng_wr.b_data = y1;
	end

	// one pulse per write-back
	assign o_butterfly_done = wr_en;

endmodule

`default_nettype wire

/* src/fft16_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fft16_top #(
	parameter int data_w = fft_pkg::data_w,
	parameter int frac_w = fft_pkg::frac_w
) (
	input wire logic i_clk,
	input wire logic rst,
	input wire logic ld_en,
	input wire logic [fft_pkg::addr_w-1:0] ld_addr,
	input wire fft_pkg::cplx_t ld_data,
	input wire logic start,
	output logic busy,
	input wire logic [fft_pkg::addr_w-1:0] rd_addr,
	output fft_pkg::cplx_t rd_data,
	output logic o_butterfly_done,
	output logic o_fft_cycle_done,
	output logic [fft_pkg::stage_w-1:0] mux_switcher_butterfly
);

	import fft_pkg::*;

	// engine side ram requests
	ram_rd_t eng_rd;
	ram_wr_t eng_wr;
	// granted requests into the ram
	ram_rd_t ram_rd;
	ram_wr_t ram_wr;
	// ram read data
	cplx_t a_q;
	cplx_t b_q;
	// twiddle path
	logic [addr_w-2:0] tw_idx;
	cplx_t tw;
	// butterfly results
	cplx_t y0;
	cplx_t y1;

	fft_sequencer u_seq (
		.i_clk(i_clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.stage(mux_switcher_butterfly),
		.eng_rd(eng_rd),
		.tw_idx(tw_idx),
		.y0(y0),
		.y1(y1),
		.eng_wr(eng_wr),
		.o_butterfly_done(o_butterfly_done),
		.o_fft_cycle_done(o_fft_cycle_done)
	);

	// host or engine onto the ram
	fft_mem_arbiter u_arb (
		.i_clk(i_clk),
		.rst(rst),
		.busy(busy),
		.eng_rd(eng_rd),
		.eng_wr(eng_wr),
		.ld_en(ld_en),
		.ld_addr(ld_addr),
		.ld_data(ld_data),
		.rd_addr(rd_addr),
		.ram_rd(ram_rd),
		.ram_wr(ram_wr),
		.a_q(a_q),
		.rd_data(rd_data)
	);

	fft_sample_ram u_ram (
		.i_clk(i_clk),
		.rd(ram_rd),
		.wr(ram_wr),
		.a_q(a_q),
		.b_q(b_q)
	);

	fft_twiddle_rom #(
		.data_w(data_w),
		.frac_w(frac_w)
	) u_rom (
		.i_clk(i_clk),
		.idx(tw_idx),
		.tw(tw)
	);

	// single butterfly, shared by all 32
	fft_butterfly #(
		.data_w(data_w),
		.frac_w(frac_w)
	) u_bfly (
		.i_clk(i_clk),
		.rst(rst),
		.a(a_q),
		.b(b_q),
		.tw(tw),
		.y0(y0),
		.y1(y1)
	);

endmodule

`default_nettype wire

/* verif/fft16_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fft16_assert (
	input wire logic i_clk,
	input wire logic rst,
	input wire logic busy,
	input wire logic o_butterfly_done,
	input wire logic o_fft_cycle_done
);

	// end of transform is a single-cycle pulse
	done_one_cycle: assert property (@(posedge i_clk) disable iff (rst)
		o_fft_cycle_done |=> !o_fft_cycle_done)
		else $error("o_fft_cycle_done held for more than one cycle");

	// busy only drops on the done pulse
	busy_falls_on_done: assert property (@(posedge i_clk) disable iff (rst)
		$fell(busy) |-> o_fft_cycle_done)
		else $error("busy fell without o_fft_cycle_done");

	// and the done cycle already sees busy low
	done_clears_busy: assert property (@(posedge i_clk) disable iff (rst)
		o_fft_cycle_done |-> !busy)
		else $error("busy still high with o_fft_cycle_done");

	// write-backs only happen inside a transform
	no_bf_done_idle: assert property (@(posedge i_clk) disable iff (rst)
		o_butterfly_done |-> busy)
		else $error("o_butterfly_done while idle");

endmodule

bind fft16_top fft16_assert u_assert (
	.i_clk(i_clk),
	.rst(rst),
	.busy(busy),
	.o_butterfly_done(o_butterfly_done),
	.o_fft_cycle_done(o_fft_cycle_done)
);

`default_nettype wire

/* verif/fft16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fft16_tb;

	import fft_pkg::*;

	// four stages of ten cycles plus the done cycle
	localparam int run_cycles = 41;
	// eight issue cycles and two drain cycles per stage
	localparam int stage_cycles = 10;
	localparam int run_timeout = 200;
	localparam int bf_total = 32;
	localparam real pi = 3.14159265358979;

	logic i_clk;
	logic rst;
	logic ld_en;
	logic [addr_w-1:0] ld_addr;
	cplx_t ld_data;
	logic start;
	logic busy;
	logic [addr_w-1:0] rd_addr;
	cplx_t rd_data;
	logic o_butterfly_done;
	logic o_fft_cycle_done;
	logic [stage_w-1:0] stage;

	// frame under test, natural order
	int in_re [n_points];
	int in_im [n_points];
	// expected bins
	int exp_re [n_points];
	int exp_im [n_points];
	// bins read back from the dut
	int got_re [n_points];
	int got_im [n_points];

	logic [31:0] lfsr;
	int mismatches;
	int protocol_errs;
	int timeouts;
	bit timed_out;

	fft16_top dut (
		.i_clk(i_clk),
		.rst(rst),
		.ld_en(ld_en),
		.ld_addr(ld_addr),
		.ld_data(ld_data),
		.start(start),
		.busy(busy),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.o_butterfly_done(o_butterfly_done),
		.o_fft_cycle_done(o_fft_cycle_done),
		.mux_switcher_butterfly(stage)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// fibonacci lfsr with taps of x^32 + x^22 + x^2 + x + 1
	// stepped once per bit drawn
	function automatic int draw_bits(input int n);
		logic fb;
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	function automatic int bit_reverse(input int n);
		int r;
		r = 0;
		for (int i = 0; i < addr_w; i++) begin
			r = (r << 1) | ((n >> i) & 1);
		end
		return r;
	endfunction

	// keep the low 16 bits sign extended
	function automatic int wrap16(input int v);
		logic signed [15:0] t;
		t = v[15:0];
		return t;
	endfunction

	// W16^k in q8 rounded to nearest
	function automatic void twiddle(input int k, output int re, output int im);
		real ang;
		ang = 2.0 * pi * real'(k) / 16.0;
		re = $rtoi($floor(256.0 * $cos(ang) + 0.5));
		im = -$rtoi($floor(256.0 * $sin(ang) + 0.5));
	endfunction

	// in-place dit fft over the bit-reversed frame
	// halved every stage
	task automatic run_model;
		int wr [n_points];
		int wi [n_points];
		int span;
		int off;
		int a;
		int b;
		int tr;
		int ti;
		int pr;
		int pi_v;
		for (int n = 0; n < n_points; n++) begin
			wr[bit_reverse(n)] = in_re[n];
			wi[bit_reverse(n)] = in_im[n];
		end
		for (int s = 0; s < addr_w; s++) begin
			span = 1 << s;
			for (int j = 0; j < n_points / 2; j++) begin
				off = j % span;
				a = (j / span) * 2 * span + off;
				b = a + span;
				twiddle(off * 8 / span, tr, ti);
				// every product truncated on its own
				pr = ((wr[b] * tr) >>> frac_w) - ((wi[b] * ti) >>> frac_w);
				pi_v = ((wr[b] * ti) >>> frac_w) + ((wi[b] * tr) >>> frac_w);
				// b first since it needs the old a
				wr[b] = wrap16((wr[a] - pr) >>> 1);
				wi[b] = wrap16((wi[a] - pi_v) >>> 1);
				wr[a] = wrap16((wr[a] + pr) >>> 1);
				wi[a] = wrap16((wi[a] + pi_v) >>> 1);
			end
		end
		for (int k = 0; k < n_points; k++) begin
			exp_re[k] = wr[k];
			exp_im[k] = wi[k];
		end
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected) else begin
			mismatches++;
			$display("Mismatch %s: got %h expected %h", name, 16'(got), 16'(expected));
		end
	endtask

	task automatic load_sample(input int addr, input int re, input int im);
		@(posedge i_clk);
		ld_en <= 1'b1;
		ld_addr <= addr_w'(addr);
		ld_data <= '{re: 16'(re), im: 16'(im)};
		@(posedge i_clk);
		ld_en <= 1'b0;
	endtask

	// rd_data is registered and valid one edge after rd_addr
	task automatic read_sample(input int addr, output int re, output int im);
		@(posedge i_clk);
		rd_addr <= addr_w'(addr);
		@(posedge i_clk);
		@(negedge i_clk);
		re = rd_data.re;
		im = rd_data.im;
	endtask

	task automatic run_transform(input bit disturb);
		int cyc;
		int bf_pulses;
		int done_pulses;
		int latency;
		cyc = 0;
		bf_pulses = 0;
		done_pulses = 0;
		latency = 0;
		@(posedge i_clk);
		start <= 1'b1;
		// junk load data for the busy window
		ld_addr <= '0;
		ld_data <= '{re: 16'h7fff, im: 16'h7fff};
		while (done_pulses == 0 && cyc < run_timeout) begin
			@(posedge i_clk);
			cyc++;
			// second start and a load mid transform
			start <= disturb && cyc == 5;
			ld_en <= disturb && cyc == 5;
			@(negedge i_clk);
			if (cyc == 1) begin
				assert (busy) else begin
					protocol_errs++;
					$display("busy did not rise in the cycle after start");
				end
			end
			assert (!(o_butterfly_done && !busy)) else begin
				protocol_errs++;
				$display("o_butterfly_done pulsed while idle");
			end
			// stage steps every ten cycles of the run
			if (cyc < run_cycles) begin
				check_value("mux_switcher_butterfly", stage, (cyc - 1) / stage_cycles);
			end
			if (o_butterfly_done) begin
				bf_pulses++;
			end
			if (o_fft_cycle_done) begin
				done_pulses++;
				latency = cyc;
			end
		end
		if (done_pulses == 0) begin
			timed_out = 1'b1;
			timeouts++;
			$display("Timeout: no o_fft_cycle_done within %0d cycles of start", run_timeout);
		end else begin
			assert (!busy) else begin
				protocol_errs++;
				$display("busy still high in the o_fft_cycle_done cycle");
			end
			// quiet window where a stray second run would show
			for (int i = 0; i < 2 * run_cycles; i++) begin
				@(negedge i_clk);
				if (o_fft_cycle_done) begin
					done_pulses++;
				end
				assert (!busy) else begin
					protocol_errs++;
					$display("busy rose again after the transform ended");
				end
			end
			check_value("o_butterfly_done count", bf_pulses, bf_total);
			check_value("o_fft_cycle_done count", done_pulses, 1);
			check_value("cycles from start to o_fft_cycle_done", latency, run_cycles);
		end
	endtask

	// load, transform, read every bin and compare
	task automatic transform_and_check(input bit disturb);
		for (int n = 0; n < n_points; n++) begin
			load_sample(n, in_re[n], in_im[n]);
		end
		run_transform(disturb);
		if (!timed_out) begin
			for (int k = 0; k < n_points; k++) begin
				read_sample(k, got_re[k], got_im[k]);
				check_value($sformatf("rd_data.re bin %0d", k), got_re[k], exp_re[k]);
				check_value($sformatf("rd_data.im bin %0d", k), got_im[k], exp_im[k]);
			end
		end
	endtask

	task automatic reset_and_readback;
		int re;
		int im;
		@(negedge i_clk);
		check_value("busy", busy, 0);
		check_value("o_butterfly_done", o_butterfly_done, 0);
		check_value("o_fft_cycle_done", o_fft_cycle_done, 0);
		check_value("mux_switcher_butterfly", stage, 0);
		// slot 12 holds address 3 and slot 6 holds address 6
		load_sample(3, 'h1234, -300);
		load_sample(6, 'h0abc, 'h7001);
		read_sample(bit_reverse(3), re, im);
		check_value("rd_data.re", re, 'h1234);
		check_value("rd_data.im", im, -300);
		read_sample(bit_reverse(6), re, im);
		check_value("rd_data.re", re, 'h0abc);
		check_value("rd_data.im", im, 'h7001);
	endtask

	// 16.0 at sample 0 gives a flat 1.0 spectrum after the /16
	task automatic impulse_response;
		for (int n = 0; n < n_points; n++) begin
			in_re[n] = (n == 0) ? 'h1000 : 0;
			in_im[n] = 0;
			exp_re[n] = 'h0100;
			exp_im[n] = 0;
		end
		transform_and_check(1'b0);
	endtask

	// dc only so everything lands in bin 0
	task automatic dc_response;
		for (int n = 0; n < n_points; n++) begin
			in_re[n] = 'h0100;
			in_im[n] = 0;
			exp_re[n] = (n == 0) ? 'h0100 : 0;
			exp_im[n] = 0;
		end
		transform_and_check(1'b0);
	endtask

	task automatic random_frame;
		int v;
		// 14-bit signed samples
		for (int n = 0; n < n_points; n++) begin
			v = draw_bits(14);
			in_re[n] = (v >= 8192) ? v - 16384 : v;
			v = draw_bits(14);
			in_im[n] = (v >= 8192) ? v - 16384 : v;
		end
		run_model();
	endtask

	task automatic random_transforms(input int frames);
		for (int f = 0; f < frames && !timed_out; f++) begin
			random_frame();
			transform_and_check(1'b0);
		end
	endtask

	// start and load while busy must both be dropped
	task automatic busy_ignores_host;
		random_frame();
		transform_and_check(1'b1);
	endtask

	initial begin
		rst = 1'b1;
		ld_en = 1'b0;
		ld_addr = '0;
		ld_data = '0;
		start = 1'b0;
		rd_addr = '0;
		lfsr = 32'h003dd9a7;
		mismatches = 0;
		protocol_errs = 0;
		timeouts = 0;
		timed_out = 1'b0;
		repeat (3) @(posedge i_clk);
		rst <= 1'b0;
		reset_and_readback();
		if (!timed_out) begin
			impulse_response();
		end
		if (!timed_out) begin
			dc_response();
		end
		if (!timed_out) begin
			random_transforms(5);
		end
		if (!timed_out) begin
			busy_ignores_host();
		end
		$display("errors: %0d mismatch, %0d protocol, %0d timeout",
			mismatches, protocol_errs, timeouts);
		if (mismatches + protocol_errs + timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
src/fft_pkg.sv
src/fft_twiddle_rom.sv
src/fft_butterfly.sv
src/fft_sample_ram.sv
src/fft_mem_arbiter.sv
src/fft_sequencer.sv
src/fft16_top.sv
verif/fft16_assert.sv
verif/fft16_tb.sv

/* Makefile */
# Verilator build and run of the 16-point FFT testbench
TOP := fft16_tb

all: run

obj_dir/V$(TOP): src.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Everything OK" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
